//--- common/rename_cfg_pkg.sv
// register file sizes, decode lane count
// and the register index types of the rename stage

`default_nettype none

package rename_cfg_pkg;

  // ============================================================
  // sizes
  // ============================================================
  localparam int LANES     = 2;
  localparam int ARCH_REGS = 32;
  localparam int PHYS_REGS = 64;

  // registers above the identity-mapped set start out free
  localparam int FL_DEPTH  = PHYS_REGS - ARCH_REGS;

  // ============================================================
  // register index types
  // ============================================================
  typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
  typedef logic [$clog2(PHYS_REGS)-1:0] preg_t;

  // one extra bit so a full list (FL_DEPTH) fits
  typedef logic [$clog2(FL_DEPTH+1)-1:0] fl_cnt_t;

endpackage

`default_nettype wire

//--- common/isa_pkg.sv
// instruction class codes, exception codes
// and the privilege level at which privileged ops fault

`default_nettype none

package isa_pkg;

  typedef logic [2:0] itype_t;
  typedef logic [5:0] ecode_t;

  // instruction classes
  localparam itype_t ITYPE_ALU     = 3'd0;
  localparam itype_t ITYPE_MDU     = 3'd1;
  localparam itype_t ITYPE_MEM     = 3'd2;
  localparam itype_t ITYPE_BR      = 3'd3;
  localparam itype_t ITYPE_PRIV    = 3'd4;
  localparam itype_t ITYPE_SYSCALL = 3'd5;
  localparam itype_t ITYPE_BREAK   = 3'd6;

  // exception codes
  localparam ecode_t ECODE_INT = 6'h00;
  localparam ecode_t ECODE_SYS = 6'h0B;
  localparam ecode_t ECODE_BRK = 6'h0C;
  localparam ecode_t ECODE_INE = 6'h0D;
  localparam ecode_t ECODE_IPE = 6'h0E;

  // user mode
  localparam logic [1:0] PLV_USER = 2'd3;

endpackage

`default_nettype wire

//--- rename/free_list.sv
// circular free list of physical registers
// two-wide allocate from the head, two-wide release at the tail

`timescale 1ns/1ps
`default_nettype none

module free_list (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic [rename_cfg_pkg::LANES-1:0]                    need_i,
  output logic                                                grant_o,
  output rename_cfg_pkg::preg_t [rename_cfg_pkg::LANES-1:0]   alloc_preg_o,
  input  logic [rename_cfg_pkg::LANES-1:0]                    free_valid_i,
  input  rename_cfg_pkg::preg_t [rename_cfg_pkg::LANES-1:0]   free_preg_i
);

  import rename_cfg_pkg::*;

  localparam int PTR_W = $clog2(FL_DEPTH);

  preg_t                       entries_q [FL_DEPTH];
  logic [PTR_W-1:0]            head_q;
  logic [PTR_W-1:0]            tail_q;
  fl_cnt_t                     count_q;

  fl_cnt_t                     need_cnt;
  fl_cnt_t                     push_cnt;
  fl_cnt_t                     pop_cnt;
  logic [LANES-1:0][PTR_W-1:0] rd_ptr;
  logic [LANES-1:0][PTR_W-1:0] wr_ptr;

  // ============================================================
  // grant and per-lane slot selection
  // ============================================================
  always_comb begin
    need_cnt = '0;
    push_cnt = '0;
    for (int l = 0; l < LANES; l++) begin
      need_cnt = need_cnt + fl_cnt_t'(need_i[l]);
      push_cnt = push_cnt + fl_cnt_t'(free_valid_i[l]);
    end

    grant_o = (count_q >= need_cnt);
    pop_cnt = grant_o ? need_cnt : '0;

    // a lane skips the slots taken by lower lanes
    rd_ptr[0] = head_q;
    wr_ptr[0] = tail_q;
    for (int l = 1; l < LANES; l++) begin
      rd_ptr[l] = rd_ptr[l-1] + PTR_W'(need_i[l-1]);
      wr_ptr[l] = wr_ptr[l-1] + PTR_W'(free_valid_i[l-1]);
    end

    for (int l = 0; l < LANES; l++) begin
      alloc_preg_o[l] = need_i[l] ? entries_q[rd_ptr[l]] : '0;
    end
  end

  // ============================================================
  // state update
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // full list, holding ARCH_REGS .. PHYS_REGS-1 in order
      for (int i = 0; i < FL_DEPTH; i++) begin
        entries_q[i] <= preg_t'(ARCH_REGS + i);
      end
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= fl_cnt_t'(FL_DEPTH);
    end else begin
      head_q  <= head_q + PTR_W'(pop_cnt);
      tail_q  <= tail_q + PTR_W'(push_cnt);
      count_q <= count_q - pop_cnt + push_cnt;
      for (int l = 0; l < LANES; l++) begin
        if (free_valid_i[l]) begin
          entries_q[wr_ptr[l]] <= free_preg_i[l];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rename/reg_alias_table.sv
// architectural to physical register map
// two-lane lookup with in-group bypass, and update

`timescale 1ns/1ps
`default_nettype none

module reg_alias_table (
  input  logic                                                    clk,
  input  logic                                                    rst_n,
  input  rename_cfg_pkg::arch_reg_t [rename_cfg_pkg::LANES-1:0]   src0_i,
  input  rename_cfg_pkg::arch_reg_t [rename_cfg_pkg::LANES-1:0]   src1_i,
  input  rename_cfg_pkg::arch_reg_t [rename_cfg_pkg::LANES-1:0]   dest_i,
  input  logic [rename_cfg_pkg::LANES-1:0]                        we_i,
  input  rename_cfg_pkg::preg_t [rename_cfg_pkg::LANES-1:0]       new_preg_i,
  output rename_cfg_pkg::preg_t [rename_cfg_pkg::LANES-1:0]       psrc0_o,
  output rename_cfg_pkg::preg_t [rename_cfg_pkg::LANES-1:0]       psrc1_o,
  output rename_cfg_pkg::preg_t [rename_cfg_pkg::LANES-1:0]       old_pdest_o
);

  import rename_cfg_pkg::*;

  preg_t map_q [ARCH_REGS];

  // table read, then override with renames from older lanes
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      psrc0_o[l]     = map_q[src0_i[l]];
      psrc1_o[l]     = map_q[src1_i[l]];
      old_pdest_o[l] = map_q[dest_i[l]];
      // youngest older writer wins, so scan upward
      for (int j = 0; j < l; j++) begin
        if (we_i[j] && dest_i[j] != '0) begin
          if (src0_i[l] == dest_i[j]) begin
            psrc0_o[l] = new_preg_i[j];
          end
          if (src1_i[l] == dest_i[j]) begin
            psrc1_o[l] = new_preg_i[j];
          end
          if (dest_i[l] == dest_i[j]) begin
            old_pdest_o[l] = new_preg_i[j];
          end
        end
      end
    end
  end

  // identity map out of reset
  // r0 is never written and stays on p0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        map_q[i] <= preg_t'(i);
      end
    end else begin
      // later lanes overwrite earlier ones on the same entry
      for (int l = 0; l < LANES; l++) begin
        if (we_i[l] && dest_i[l] != '0) begin
          map_q[dest_i[l]] <= new_preg_i[l];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/excp_check.sv
// per-lane exception check
// priority INT > INE > IPE > SYS > BRK

`timescale 1ns/1ps
`default_nettype none

module excp_check (
  input  logic [rename_cfg_pkg::LANES-1:0]                  in_valid_i,
  input  isa_pkg::itype_t [rename_cfg_pkg::LANES-1:0]       in_itype_i,
  input  logic [rename_cfg_pkg::LANES-1:0]                  in_invalid_i,
  input  logic                                              csr_has_int_i,
  input  logic [1:0]                                        csr_plv_i,
  output logic [rename_cfg_pkg::LANES-1:0]                  excp_o,
  output isa_pkg::ecode_t [rename_cfg_pkg::LANES-1:0]       ecode_o
);

  import rename_cfg_pkg::*;
  import isa_pkg::*;

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      excp_o[l]  = 1'b0;
      ecode_o[l] = '0;
      if (in_valid_i[l]) begin
        excp_o[l] = 1'b1;
        if (csr_has_int_i) begin
          ecode_o[l] = ECODE_INT;
        end else if (in_invalid_i[l]) begin
          ecode_o[l] = ECODE_INE;
        end else if (in_itype_i[l] == ITYPE_PRIV && csr_plv_i == PLV_USER) begin
          ecode_o[l] = ECODE_IPE;
        end else if (in_itype_i[l] == ITYPE_SYSCALL) begin
          ecode_o[l] = ECODE_SYS;
        end else if (in_itype_i[l] == ITYPE_BREAK) begin
          ecode_o[l] = ECODE_BRK;
        end else begin
          // clean instruction
          excp_o[l] = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/rename_stage.sv
// two-lane rename stage top level
// input acceptance, free list / RAT / exception wiring, output registers

`timescale 1ns/1ps
`default_nettype none

module rename_stage (
  input  logic                                                  clk,
  input  logic                                                  rst_n,

  // decode side
  input  logic [rename_cfg_pkg::LANES-1:0]                      in_valid_i,
  output logic                                                  in_ready_o,
  input  isa_pkg::itype_t [rename_cfg_pkg::LANES-1:0]           in_itype_i,
  input  logic [rename_cfg_pkg::LANES-1:0]                      in_invalid_i,
  input  rename_cfg_pkg::arch_reg_t [rename_cfg_pkg::LANES-1:0] in_src0_i,
  input  rename_cfg_pkg::arch_reg_t [rename_cfg_pkg::LANES-1:0] in_src1_i,
  input  rename_cfg_pkg::arch_reg_t [rename_cfg_pkg::LANES-1:0] in_dest_i,

  // csr state
  input  logic                                                  csr_has_int_i,
  input  logic [1:0]                                            csr_plv_i,

  // commit side register release
  input  logic [rename_cfg_pkg::LANES-1:0]                      free_valid_i,
  input  rename_cfg_pkg::preg_t [rename_cfg_pkg::LANES-1:0]     free_preg_i,

  // renamed group
  output logic [rename_cfg_pkg::LANES-1:0]                      out_valid_o,
  output rename_cfg_pkg::preg_t [rename_cfg_pkg::LANES-1:0]     out_psrc0_o,
  output rename_cfg_pkg::preg_t [rename_cfg_pkg::LANES-1:0]     out_psrc1_o,
  output rename_cfg_pkg::preg_t [rename_cfg_pkg::LANES-1:0]     out_pdest_o,
  output rename_cfg_pkg::preg_t [rename_cfg_pkg::LANES-1:0]     out_old_pdest_o,
  output logic [rename_cfg_pkg::LANES-1:0]                      out_excp_o,
  output isa_pkg::ecode_t [rename_cfg_pkg::LANES-1:0]           out_ecode_o
);

  import rename_cfg_pkg::*;
  import isa_pkg::*;

  logic [LANES-1:0]          excp;
  ecode_t [LANES-1:0]        ecode;
  logic [LANES-1:0]          need;
  logic                      grant;
  logic                      accept;
  logic [LANES-1:0]          rat_we;
  preg_t [LANES-1:0]         alloc_preg;
  preg_t [LANES-1:0]         rat_psrc0;
  preg_t [LANES-1:0]         rat_psrc1;
  preg_t [LANES-1:0]         rat_old_pdest;

  // ============================================================
  // acceptance and need mask
  // ============================================================
  excp_check u_excp_check (
    .in_valid_i    (in_valid_i),
    .in_itype_i    (in_itype_i),
    .in_invalid_i  (in_invalid_i),
    .csr_has_int_i (csr_has_int_i),
    .csr_plv_i     (csr_plv_i),
    .excp_o        (excp),
    .ecode_o       (ecode)
  );

  // only clean lanes with a real destination take a register
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      need[l] = in_valid_i[l] & ~excp[l] & (in_dest_i[l] != '0);
    end
  end

  assign in_ready_o = grant;
  assign accept     = (|in_valid_i) & grant;
  assign rat_we     = need & {LANES{accept}};

  // ============================================================
  // free list and RAT
  // ============================================================
  free_list u_free_list (
    .clk          (clk),
    .rst_n        (rst_n),
    .need_i       (need),
    .grant_o      (grant),
    .alloc_preg_o (alloc_preg),
    .free_valid_i (free_valid_i),
    .free_preg_i  (free_preg_i)
  );

  reg_alias_table u_rat (
    .clk         (clk),
    .rst_n       (rst_n),
    .src0_i      (in_src0_i),
    .src1_i      (in_src1_i),
    .dest_i      (in_dest_i),
    .we_i        (rat_we),
    .new_preg_i  (alloc_preg),
    .psrc0_o     (rat_psrc0),
    .psrc1_o     (rat_psrc1),
    .old_pdest_o (rat_old_pdest)
  );

  // ============================================================
  // output registers
  // ============================================================
  // one-cycle strobe per accepted group
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_o <= '0;
    end else begin
      out_valid_o <= accept ? in_valid_i : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_psrc0_o <= rat_psrc0;
      out_psrc1_o <= rat_psrc1;
      out_excp_o  <= excp;
      out_ecode_o <= ecode;
      for (int l = 0; l < LANES; l++) begin
        // free list already zeroes pdest for lanes that need nothing
        out_pdest_o[l]     <= alloc_preg[l];
        out_old_pdest_o[l] <= need[l] ? rat_old_pdest[l] : '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/rename_stage_props.sv
// bound assertions on the rename stage top level
// strobe timing, ready after reset, destination allocation

`timescale 1ns/1ps
`default_nettype none

module rename_stage_props (
  input logic                                                  clk,
  input logic                                                  rst_n,
  input logic [rename_cfg_pkg::LANES-1:0]                      in_valid_i,
  input logic                                                  in_ready_o,
  input rename_cfg_pkg::arch_reg_t [rename_cfg_pkg::LANES-1:0] in_dest_i,
  input logic [rename_cfg_pkg::LANES-1:0]                      out_valid_o,
  input rename_cfg_pkg::preg_t [rename_cfg_pkg::LANES-1:0]     out_pdest_o,
  input logic [rename_cfg_pkg::LANES-1:0]                      out_excp_o
);

  import rename_cfg_pkg::*;

  // a result only follows an accepted group
  a_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid_o != '0) |-> $past((in_valid_i != '0) && in_ready_o))
    else $error("out_valid_o set without an accepted group");

  a_ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> in_ready_o)
    else $error("in_ready_o low in the first cycle after reset");

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    a_pdest: assert property (@(posedge clk) disable iff (!rst_n)
      (out_valid_o[l] && !out_excp_o[l] && ($past(in_dest_i[l]) != '0))
        |-> (out_pdest_o[l] != '0))
      else $error("lane %0d renamed without a physical register", l);
  end

endmodule

bind rename_stage rename_stage_props u_props (.*);

`default_nettype wire

//--- verif/rename_stage_tb.sv
// testbench for the two-lane rename stage
// directed and random groups checked against a reference model

`timescale 1ns/1ps
`default_nettype none

module rename_stage_tb;

  import rename_cfg_pkg::*;
  import isa_pkg::*;

  localparam int TIMEOUT = 50;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic [LANES-1:0]      in_valid;
  logic                  in_ready;
  itype_t [LANES-1:0]    in_itype;
  logic [LANES-1:0]      in_invalid;
  arch_reg_t [LANES-1:0] in_src0;
  arch_reg_t [LANES-1:0] in_src1;
  arch_reg_t [LANES-1:0] in_dest;
  logic                  csr_has_int;
  logic [1:0]            csr_plv;
  logic [LANES-1:0]      free_valid;
  preg_t [LANES-1:0]     free_preg;
  logic [LANES-1:0]      out_valid;
  preg_t [LANES-1:0]     out_psrc0;
  preg_t [LANES-1:0]     out_psrc1;
  preg_t [LANES-1:0]     out_pdest;
  preg_t [LANES-1:0]     out_old_pdest;
  logic [LANES-1:0]      out_excp;
  ecode_t [LANES-1:0]    out_ecode;

  // reference model state
  preg_t            rat_m [ARCH_REGS];
  preg_t            free_q [$];
  preg_t            disp_q [$];
  logic [LANES-1:0] exp_valid;
  preg_t            exp_psrc0 [LANES];
  preg_t            exp_psrc1 [LANES];
  preg_t            exp_pdest [LANES];
  preg_t            exp_old [LANES];
  logic [LANES-1:0] exp_excp;
  ecode_t           exp_ecode [LANES];
  preg_t            seen_pdest [LANES];
  logic             accepted;
  logic             got_out;
  logic             release_on;
  logic             saw_stall;

  always #5 clk = ~clk;

  rename_stage UUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid_i      (in_valid),
    .in_ready_o      (in_ready),
    .in_itype_i      (in_itype),
    .in_invalid_i    (in_invalid),
    .in_src0_i       (in_src0),
    .in_src1_i       (in_src1),
    .in_dest_i       (in_dest),
    .csr_has_int_i   (csr_has_int),
    .csr_plv_i       (csr_plv),
    .free_valid_i    (free_valid),
    .free_preg_i     (free_preg),
    .out_valid_o     (out_valid),
    .out_psrc0_o     (out_psrc0),
    .out_psrc1_o     (out_psrc1),
    .out_pdest_o     (out_pdest),
    .out_old_pdest_o (out_old_pdest),
    .out_excp_o      (out_excp),
    .out_ecode_o     (out_ecode)
  );

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_error(input string msg);
    abort_run($sformatf("Error at %0t ns: %s", $time, msg));
  endtask

  // ============================================================
  // model rules
  // ============================================================
  // bit 6 flags an exception, bits 5:0 hold its code
  function automatic logic [6:0] lane_exception(input int l);
    if (!in_valid[l]) return '0;
    if (csr_has_int) return {1'b1, ECODE_INT};
    if (in_invalid[l]) return {1'b1, ECODE_INE};
    if (in_itype[l] == ITYPE_PRIV && csr_plv == PLV_USER) return {1'b1, ECODE_IPE};
    if (in_itype[l] == ITYPE_SYSCALL) return {1'b1, ECODE_SYS};
    if (in_itype[l] == ITYPE_BREAK) return {1'b1, ECODE_BRK};
    return '0;
  endfunction

  function automatic logic lane_needs(input int l);
    logic [6:0] ex;
    ex = lane_exception(l);
    return in_valid[l] && !ex[6] && (in_dest[l] != '0);
  endfunction

  task automatic compare_outputs();
    got_out = (out_valid != '0);
    assert (out_valid == exp_valid)
      else report_error($sformatf("out_valid_o %b, expected %b", out_valid, exp_valid));
    for (int l = 0; l < LANES; l++) begin
      if (exp_valid[l]) begin
        assert (out_psrc0[l] == exp_psrc0[l] && out_psrc1[l] == exp_psrc1[l])
          else report_error($sformatf("lane %0d sources p%0d p%0d, expected p%0d p%0d",
                            l, out_psrc0[l], out_psrc1[l], exp_psrc0[l], exp_psrc1[l]));
        assert (out_pdest[l] == exp_pdest[l] && out_old_pdest[l] == exp_old[l])
          else report_error($sformatf("lane %0d pdest p%0d old p%0d, expected p%0d old p%0d",
                            l, out_pdest[l], out_old_pdest[l], exp_pdest[l], exp_old[l]));
        assert (out_excp[l] == exp_excp[l] && out_ecode[l] == exp_ecode[l])
          else report_error($sformatf("lane %0d excp %b code 0x%0h, expected %b 0x%0h",
                            l, out_excp[l], out_ecode[l], exp_excp[l], exp_ecode[l]));
        seen_pdest[l] = out_pdest[l];
      end
    end
  endtask

  // sample at the falling edge, drive at the rising edge
  task automatic step_cycle();
    int         n_need;
    logic [6:0] ex;
    preg_t      np;
    @(negedge clk);
    compare_outputs();
    n_need = 0;
    for (int l = 0; l < LANES; l++) begin
      n_need += int'(lane_needs(l));
    end
    assert (in_ready == (free_q.size() >= n_need))
      else report_error($sformatf("in_ready_o %b with %0d free and %0d needed",
                        in_ready, free_q.size(), n_need));
    accepted = (in_valid != '0) && in_ready;
    if (in_valid != '0 && !in_ready) saw_stall = 1'b1;
    exp_valid = accepted ? in_valid : '0;
    if (accepted) begin
      // lanes in order, so lane 1 sees lane 0's rename
      for (int l = 0; l < LANES; l++) begin
        ex = lane_exception(l);
        exp_excp[l]  = ex[6];
        exp_ecode[l] = ex[5:0];
        exp_psrc0[l] = rat_m[in_src0[l]];
        exp_psrc1[l] = rat_m[in_src1[l]];
        exp_pdest[l] = '0;
        exp_old[l]   = '0;
        if (lane_needs(l)) begin
          np           = free_q.pop_front();
          exp_old[l]   = rat_m[in_dest[l]];
          exp_pdest[l] = np;
          disp_q.push_back(exp_old[l]);
          rat_m[in_dest[l]] = np;
        end
      end
    end
    // releases land at the coming edge, after this allocation
    for (int l = 0; l < LANES; l++) begin
      if (free_valid[l]) free_q.push_back(free_preg[l]);
    end
    @(posedge clk);
    free_valid <= '0;
    if (release_on) begin
      for (int l = 0; l < LANES; l++) begin
        if (disp_q.size() > 0 && $urandom_range(0, 2) == 0) begin
          free_valid[l] <= 1'b1;
          free_preg[l]  <= disp_q.pop_front();
        end
      end
    end
  endtask

  // ============================================================
  // stimulus
  // ============================================================
  task automatic send_group();
    int n;
    n = 0;
    accepted = 1'b0;
    while (!accepted) begin
      if (n == TIMEOUT) abort_run($sformatf("timeout: in_ready_o low for %0d cycles", n));
      step_cycle();
      n++;
    end
    in_valid <= '0;
    n = 0;
    got_out = 1'b0;
    while (!got_out) begin
      if (n == TIMEOUT) abort_run($sformatf("timeout: no out_valid_o for %0d cycles", n));
      step_cycle();
      n++;
    end
  endtask

  task automatic drive_lane(input int l, input itype_t t, input logic inv,
                            input int s0, input int s1, input int d);
    in_itype[l]   <= t;
    in_invalid[l] <= inv;
    in_src0[l]    <= arch_reg_t'(s0);
    in_src1[l]    <= arch_reg_t'(s1);
    in_dest[l]    <= arch_reg_t'(d);
  endtask

  // lane 1 often reuses lane 0's destination
  function automatic arch_reg_t dependent_reg(input arch_reg_t d0);
    return ($urandom_range(0, 2) == 0) ? d0 : arch_reg_t'($urandom);
  endfunction

  task automatic drive_random_group();
    arch_reg_t d0;
    d0 = arch_reg_t'($urandom);
    for (int l = 0; l < LANES; l++) begin
      in_itype[l]   <= ($urandom_range(0, 9) < 7) ? itype_t'($urandom_range(0, 3))
                                                  : itype_t'($urandom_range(4, 6));
      in_invalid[l] <= ($urandom_range(0, 15) == 0);
    end
    in_src0[0]  <= arch_reg_t'($urandom);
    in_src1[0]  <= arch_reg_t'($urandom);
    in_dest[0]  <= d0;
    in_src0[1]  <= dependent_reg(d0);
    in_src1[1]  <= dependent_reg(d0);
    in_dest[1]  <= dependent_reg(d0);
    csr_has_int <= ($urandom_range(0, 31) == 0);
    csr_plv     <= 2'($urandom_range(0, 3));
    in_valid    <= LANES'($urandom_range(1, 3));
  endtask

  initial begin
    void'($urandom(39450));
    rst_n       = 1'b0;
    in_valid    = '0;
    in_itype    = '0;
    in_invalid  = '0;
    in_src0     = '0;
    in_src1     = '0;
    in_dest     = '0;
    csr_has_int = 1'b0;
    csr_plv     = 2'd0;
    free_valid  = '0;
    free_preg   = '0;
    exp_valid   = '0;
    release_on  = 1'b1;
    saw_stall   = 1'b0;
    for (int i = 0; i < ARCH_REGS; i++) begin
      rat_m[i] = preg_t'(i);
    end
    for (int i = 0; i < FL_DEPTH; i++) begin
      free_q.push_back(preg_t'(ARCH_REGS + i));
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (in_ready) else report_error("in_ready_o low after reset");
    @(posedge clk);

    // first group takes the head of the free list
    drive_lane(0, ITYPE_ALU, 1'b0, 1, 2, 5);
    drive_lane(1, ITYPE_ALU, 1'b0, 3, 4, 6);
    in_valid <= 2'b11;
    send_group();
    assert (seen_pdest[0] == 6'd32 && seen_pdest[1] == 6'd33)
      else report_error($sformatf("first group got p%0d p%0d", seen_pdest[0], seen_pdest[1]));

    // dependent pairs, same destination in both lanes
    drive_lane(0, ITYPE_ALU, 1'b0, 1, 2, 7);
    drive_lane(1, ITYPE_ALU, 1'b0, 7, 7, 7);
    in_valid <= 2'b11;
    send_group();
    drive_lane(0, ITYPE_MEM, 1'b0, 3, 4, 8);
    drive_lane(1, ITYPE_BR, 1'b0, 9, 8, 9);
    in_valid <= 2'b11;
    send_group();

    // ============================================================
    // exception priority
    // ============================================================
    csr_has_int <= 1'b1;
    csr_plv     <= PLV_USER;
    drive_lane(0, ITYPE_ALU, 1'b1, 1, 1, 10);
    drive_lane(1, ITYPE_PRIV, 1'b0, 1, 1, 11);
    in_valid <= 2'b11;
    send_group();
    csr_has_int <= 1'b0;
    in_valid    <= 2'b11;
    send_group();
    csr_plv <= 2'd0;
    drive_lane(0, ITYPE_SYSCALL, 1'b0, 2, 3, 12);
    in_valid <= 2'b11;
    send_group();
    drive_lane(0, ITYPE_BREAK, 1'b0, 2, 3, 14);
    drive_lane(1, ITYPE_ALU, 1'b0, 4, 5, 0);
    in_valid <= 2'b11;
    send_group();

    repeat (400) begin
      drive_random_group();
      send_group();
    end

    // ============================================================
    // drain the free list with releases held back
    // ============================================================
    release_on  = 1'b0;
    saw_stall   = 1'b0;
    csr_has_int <= 1'b0;
    drive_lane(0, ITYPE_ALU, 1'b0, 1, 2, 14);
    drive_lane(1, ITYPE_ALU, 1'b0, 3, 4, 15);
    while (free_q.size() >= 2) begin
      in_valid <= 2'b11;
      send_group();
    end
    in_valid <= 2'b11;
    step_cycle();
    assert (saw_stall) else report_error("in_ready_o stayed high with too few free registers");
    release_on = 1'b1;
    send_group();

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
common/rename_cfg_pkg.sv
common/isa_pkg.sv
rename/free_list.sv
rename/reg_alias_table.sv
design/excp_check.sv
design/rename_stage.sv
verif/rename_stage_props.sv
verif/rename_stage_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rename stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module rename_stage_tb -o rename_stage_sim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/rename_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see $LOG"
exit 1
